/* cp0_pkg.sv */
package cp0_pkg;

    localparam int DATA_W = 32;

    // coprocessor 0 register numbers
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        PRID     = 5'd15,
        CONFIG   = 5'd16
    } cp0_addr_e;

    // status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 10;
    localparam int STATUS_IM_HI = 15;

    // cause fields
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 10;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_BD     = 31;

    localparam logic [DATA_W-1:0] STATUS_RESET   = 32'h0000_0000;
    localparam logic [DATA_W-1:0] CAUSE_RESET    = 32'h0000_0000;
    localparam logic [DATA_W-1:0] EPC_RESET      = 32'h0000_0000;
    localparam logic [DATA_W-1:0] BADVADDR_RESET = 32'h0000_0000;
    localparam logic [DATA_W-1:0] PRID_RESET     = 32'h0001_8000;
    localparam logic [DATA_W-1:0] CONFIG_RESET   = 32'h0000_8000;

    // software-writable bits
    localparam logic [DATA_W-1:0] STATUS_MASK = 32'h0000_fc03;
    localparam logic [DATA_W-1:0] CAUSE_MASK  = 32'h0000_0000;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exccode_e;

endpackage

/* exc_pkg.sv */
package exc_pkg;

    // declaration order is the priority order, highest first after NONE
    typedef enum logic [3:0] {
        NONE,
        INT,
        ADEL_IF,
        ADEL,
        ADES,
        RI,
        OV,
        BP,
        SYS,
        ERET
    } exc_type_e;

    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

    // one flag per synchronous exception source of the pipeline
    typedef struct packed {
        logic adel_if;
        logic adel;
        logic ades;
        logic ri;
        logic ov;
        logic bp;
        logic sys;
        logic eret;
    } exc_flags_t;

endpackage

/* cp0_access_if.sv */
interface cp0_access_if;

    logic                          wr_en;
    cp0_pkg::cp0_addr_e            wr_addr;
    logic [cp0_pkg::DATA_W-1:0]    wr_data;
    cp0_pkg::cp0_addr_e            rd_addr;
    logic [cp0_pkg::DATA_W-1:0]    rd_data;

    modport bus (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data
    );

    modport regs (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

/* exc_if.sv */
interface exc_if;

    exc_pkg::exc_type_e            exc_type;
    logic                          delayslot;
    logic [cp0_pkg::DATA_W-1:0]    pc;
    logic [cp0_pkg::DATA_W-1:0]    badvaddr;

    // committed on the edge where exc_type is not NONE
    modport src (
        output exc_type,
        output delayslot,
        output pc,
        output badvaddr
    );

    modport sink (
        input exc_type,
        input delayslot,
        input pc,
        input badvaddr
    );

endinterface

/* cp0_wb_slave.sv */
module cp0_wb_slave (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  cp0_pkg::cp0_addr_e            wb_adr,
    input  logic [cp0_pkg::DATA_W-1:0]    wb_dat_i,
    output logic [cp0_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                          wb_ack,
    cp0_access_if.bus                     acc
);

    typedef enum logic {
        IDLE,
        ACK
    } state_e;

    state_e state;
    logic   req;

    // new cycle only accepted from idle, so each access is seen once
    assign req = wb_cyc && wb_stb && (state == IDLE);

    assign acc.wr_en   = req && wb_we;
    assign acc.wr_addr = wb_adr;
    assign acc.wr_data = wb_dat_i;
    assign acc.rd_addr = wb_adr;

    assign wb_ack = (state == ACK);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= ACK;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= acc.rd_data;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |=> !wb_ack);

endmodule

/* exc_arbiter.sv */
module exc_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  exc_pkg::exc_flags_t           flags,
    input  logic [cp0_pkg::DATA_W-1:0]    pc,
    input  logic [cp0_pkg::DATA_W-1:0]    badvaddr_in,
    input  logic                          delayslot,
    input  logic [4:0]                    hw_int,
    input  logic [cp0_pkg::DATA_W-1:0]    status,
    input  logic [cp0_pkg::DATA_W-1:0]    cause,
    output logic [4:0]                    hw_int_sync,
    exc_if.src                            exc
);

    logic [4:0]         hw_int_meta;
    logic [5:0]         ip;
    logic [5:0]         im;
    logic               int_pending;
    exc_pkg::exc_type_e sel;

    // two-flop synchronizer for the async interrupt lines
    always_ff @(posedge clk) begin
        if (!rst) begin
            hw_int_meta <= '0;
            hw_int_sync <= '0;
        end else begin
            hw_int_meta <= hw_int;
            hw_int_sync <= hw_int_meta;
        end
    end

    assign ip = cause[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO];
    assign im = status[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];

    assign int_pending = status[cp0_pkg::STATUS_IE] && !status[cp0_pkg::STATUS_EXL]
                         && |(ip & im);

    // fixed priority, interrupt first
    always_comb begin
        if (int_pending)
            sel = exc_pkg::INT;
        else if (flags.adel_if)
            sel = exc_pkg::ADEL_IF;
        else if (flags.adel)
            sel = exc_pkg::ADEL;
        else if (flags.ades)
            sel = exc_pkg::ADES;
        else if (flags.ri)
            sel = exc_pkg::RI;
        else if (flags.ov)
            sel = exc_pkg::OV;
        else if (flags.bp)
            sel = exc_pkg::BP;
        else if (flags.sys)
            sel = exc_pkg::SYS;
        else if (flags.eret)
            sel = exc_pkg::ERET;
        else
            sel = exc_pkg::NONE;
    end

    assign exc.exc_type  = sel;
    assign exc.pc        = pc;
    assign exc.delayslot = delayslot;
    // fetch address error reports the pc itself
    assign exc.badvaddr  = (sel == exc_pkg::ADEL_IF) ? pc : badvaddr_in;

    a_no_int_in_exl: assert property (@(posedge clk) disable iff (!rst)
        status[cp0_pkg::STATUS_EXL] |-> (exc.exc_type != exc_pkg::INT));

endmodule

/* cp0_regs.sv */
module cp0_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [4:0]                    hw_int_sync,
    cp0_access_if.regs                    acc,
    exc_if.sink                           exc,
    output logic [cp0_pkg::DATA_W-1:0]    status,
    output logic [cp0_pkg::DATA_W-1:0]    cause,
    output logic [cp0_pkg::DATA_W-1:0]    epc
);

    logic [cp0_pkg::DATA_W-1:0] badvaddr_q;
    logic [cp0_pkg::DATA_W-1:0] count_q;
    logic [cp0_pkg::DATA_W-1:0] compare_q;
    logic [cp0_pkg::DATA_W-1:0] status_q;
    logic [cp0_pkg::DATA_W-1:0] cause_q;
    logic [cp0_pkg::DATA_W-1:0] epc_q;
    logic                       timer_int;
    logic                       exc_taken;
    logic                       addr_err;
    logic [cp0_pkg::DATA_W-1:0] exc_epc;

    function automatic logic [cp0_pkg::DATA_W-1:0] masked(
        input logic [cp0_pkg::DATA_W-1:0] old_v,
        input logic [cp0_pkg::DATA_W-1:0] new_v,
        input logic [cp0_pkg::DATA_W-1:0] mask
    );
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    function automatic cp0_pkg::exccode_e code_of(input exc_pkg::exc_type_e t);
        case (t)
            exc_pkg::ADEL_IF, exc_pkg::ADEL: code_of = cp0_pkg::ADEL;
            exc_pkg::ADES:                   code_of = cp0_pkg::ADES;
            exc_pkg::RI:                     code_of = cp0_pkg::RI;
            exc_pkg::OV:                     code_of = cp0_pkg::OV;
            exc_pkg::BP:                     code_of = cp0_pkg::BP;
            exc_pkg::SYS:                    code_of = cp0_pkg::SYS;
            default:                         code_of = cp0_pkg::INT;
        endcase
    endfunction

    assign exc_taken = (exc.exc_type != exc_pkg::NONE) && (exc.exc_type != exc_pkg::ERET);
    assign addr_err  = (exc.exc_type == exc_pkg::ADEL_IF) || (exc.exc_type == exc_pkg::ADEL)
                       || (exc.exc_type == exc_pkg::ADES);
    // branch in the delay slot restarts at the branch
    assign exc_epc   = exc.delayslot ? exc.pc - 32'd4 : exc.pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            badvaddr_q <= cp0_pkg::BADVADDR_RESET;
            count_q    <= '0;
            compare_q  <= '0;
            status_q   <= cp0_pkg::STATUS_RESET;
            cause_q    <= cp0_pkg::CAUSE_RESET;
            epc_q      <= cp0_pkg::EPC_RESET;
            timer_int  <= 1'b0;
        end else begin
            count_q <= count_q + 1'b1;
            if (compare_q != '0 && count_q == compare_q) begin
                timer_int <= 1'b1;
            end

            if (acc.wr_en) begin
                case (acc.wr_addr)
                    cp0_pkg::COUNT: begin
                        count_q <= acc.wr_data;
                    end
                    cp0_pkg::COMPARE: begin
                        compare_q <= acc.wr_data;
                        timer_int <= 1'b0;
                    end
                    cp0_pkg::STATUS: begin
                        status_q <= masked(status_q, acc.wr_data, cp0_pkg::STATUS_MASK);
                    end
                    cp0_pkg::CAUSE: begin
                        cause_q <= masked(cause_q, acc.wr_data, cp0_pkg::CAUSE_MASK);
                    end
                    cp0_pkg::EPC: begin
                        epc_q <= acc.wr_data;
                    end
                    default: begin
                    end
                endcase
            end

            // pending lines, timer on the top IP bit
            cause_q[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO] <= {timer_int, hw_int_sync};

            // exception fields override a same-cycle bus write
            if (exc_taken) begin
                epc_q                                                <= exc_epc;
                cause_q[cp0_pkg::CAUSE_BD]                           <= exc.delayslot;
                cause_q[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] <= code_of(exc.exc_type);
                status_q[cp0_pkg::STATUS_EXL]                        <= 1'b1;
                if (addr_err) begin
                    badvaddr_q <= exc.badvaddr;
                end
            end else if (exc.exc_type == exc_pkg::ERET) begin
                status_q[cp0_pkg::STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_comb begin
        case (acc.rd_addr)
            cp0_pkg::BADVADDR: acc.rd_data = badvaddr_q;
            cp0_pkg::COUNT:    acc.rd_data = count_q;
            cp0_pkg::COMPARE:  acc.rd_data = compare_q;
            cp0_pkg::STATUS:   acc.rd_data = status_q;
            cp0_pkg::CAUSE:    acc.rd_data = cause_q;
            cp0_pkg::EPC:      acc.rd_data = epc_q;
            cp0_pkg::PRID:     acc.rd_data = cp0_pkg::PRID_RESET;
            cp0_pkg::CONFIG:   acc.rd_data = cp0_pkg::CONFIG_RESET;
            default:           acc.rd_data = '0;
        endcase
    end

    assign status = status_q;
    assign cause  = cause_q;
    assign epc    = epc_q;

    a_exl_after_exc: assert property (@(posedge clk) disable iff (!rst)
        exc_taken |=> status_q[cp0_pkg::STATUS_EXL]);

endmodule

/* exc_redirect.sv */
module exc_redirect (
    input  logic                          clk,
    input  logic                          rst,
    exc_if.sink                           exc,
    input  logic [cp0_pkg::DATA_W-1:0]    epc,
    output logic                          flush,
    output logic [cp0_pkg::DATA_W-1:0]    redirect_pc
);

    logic is_eret;

    assign is_eret = (exc.exc_type == exc_pkg::ERET);

    // one-cycle pulse after the commit edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            flush <= 1'b0;
        end else begin
            flush <= (exc.exc_type != exc_pkg::NONE);
        end
    end

    // epc here is still the value from before the commit edge
    always_ff @(posedge clk) begin
        if (is_eret) begin
            redirect_pc <= epc;
        end else begin
            redirect_pc <= exc_pkg::EXC_VECTOR;
        end
    end

endmodule

/* cp0_top.sv */
module cp0_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [4:0]                    wb_adr,
    input  logic [cp0_pkg::DATA_W-1:0]    wb_dat_i,
    output logic [cp0_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                          wb_ack,
    input  exc_pkg::exc_flags_t           pipe_flags,
    input  logic [cp0_pkg::DATA_W-1:0]    pipe_pc,
    input  logic                          pipe_delayslot,
    input  logic [cp0_pkg::DATA_W-1:0]    pipe_badvaddr,
    input  logic [4:0]                    hw_int,
    output logic                          flush,
    output logic [cp0_pkg::DATA_W-1:0]    redirect_pc,
    output logic [cp0_pkg::DATA_W-1:0]    status,
    output logic [cp0_pkg::DATA_W-1:0]    cause,
    output logic [cp0_pkg::DATA_W-1:0]    epc
);

    logic [4:0] hw_int_sync;

    cp0_access_if acc_if ();
    exc_if        exc_bus ();

    cp0_wb_slave wb_slave_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (cp0_pkg::cp0_addr_e'(wb_adr)),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .acc      (acc_if.bus)
    );

    exc_arbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .flags       (pipe_flags),
        .pc          (pipe_pc),
        .badvaddr_in (pipe_badvaddr),
        .delayslot   (pipe_delayslot),
        .hw_int      (hw_int),
        .status      (status),
        .cause       (cause),
        .hw_int_sync (hw_int_sync),
        .exc         (exc_bus.src)
    );

    cp0_regs regs_i (
        .clk         (clk),
        .rst         (rst),
        .hw_int_sync (hw_int_sync),
        .acc         (acc_if.regs),
        .exc         (exc_bus.sink),
        .status      (status),
        .cause       (cause),
        .epc         (epc)
    );

    exc_redirect redirect_i (
        .clk         (clk),
        .rst         (rst),
        .exc         (exc_bus.sink),
        .epc         (epc),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

/* tb_cp0_top.sv */
module tb_cp0_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_LIMIT = 8;

    logic                clk;
    logic                rst;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [4:0]          wb_adr;
    logic [31:0]         wb_dat_i;
    logic [31:0]         wb_dat_o;
    logic                wb_ack;
    exc_pkg::exc_flags_t pipe_flags;
    logic [31:0]         pipe_pc;
    logic                pipe_delayslot;
    logic [31:0]         pipe_badvaddr;
    logic [4:0]          hw_int;
    logic                flush;
    logic [31:0]         redirect_pc;
    logic [31:0]         status;
    logic [31:0]         cause;
    logic [31:0]         epc;

    // reference model state
    logic [31:0] m_status;
    logic [31:0] m_cause;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [31:0] m_compare;
    logic [31:0] rng_state;

    cp0_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack         (wb_ack),
        .pipe_flags     (pipe_flags),
        .pipe_pc        (pipe_pc),
        .pipe_delayslot (pipe_delayslot),
        .pipe_badvaddr  (pipe_badvaddr),
        .hw_int         (hw_int),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .status         (status),
        .cause          (cause),
        .epc            (epc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // priority from the exception rules, interrupts handled apart
    function automatic exc_pkg::exc_type_e pick_exc(input exc_pkg::exc_flags_t f);
        if (f.adel_if) return exc_pkg::ADEL_IF;
        if (f.adel)    return exc_pkg::ADEL;
        if (f.ades)    return exc_pkg::ADES;
        if (f.ri)      return exc_pkg::RI;
        if (f.ov)      return exc_pkg::OV;
        if (f.bp)      return exc_pkg::BP;
        if (f.sys)     return exc_pkg::SYS;
        if (f.eret)    return exc_pkg::ERET;
        return exc_pkg::NONE;
    endfunction

    function automatic cp0_pkg::exccode_e code_for(input exc_pkg::exc_type_e t);
        case (t)
            exc_pkg::ADEL_IF: return cp0_pkg::ADEL;
            exc_pkg::ADEL:    return cp0_pkg::ADEL;
            exc_pkg::ADES:    return cp0_pkg::ADES;
            exc_pkg::RI:      return cp0_pkg::RI;
            exc_pkg::OV:      return cp0_pkg::OV;
            exc_pkg::BP:      return cp0_pkg::BP;
            exc_pkg::SYS:     return cp0_pkg::SYS;
            default:          return cp0_pkg::INT;
        endcase
    endfunction

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input cp0_pkg::exccode_e exp,
                              input cp0_pkg::exccode_e act);
        if (act !== exp) begin
            $display("ERROR time=%0t %s expected=%s(%0d) actual=%s(%0d)", $time, name,
                     exp.name(), exp, act.name(), act);
            abort_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_pkg::exc_type_e exp,
                             input exc_pkg::exc_type_e act);
        if (act !== exp) begin
            $display("ERROR time=%0t %s expected=%s actual=%s(%0d)", $time, name,
                     exp.name(), act.name(), act);
            abort_run();
        end
    endtask

    // status, cause and epc ports against the model
    task automatic compare_reg_ports();
        check_word("status", m_status, status);
        check_word("cause", m_cause, cause);
        check_word("epc", m_epc, epc);
    endtask

    // called and returns on a falling edge
    task automatic bus_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
            if (wb_ack !== 1'b1 && waited >= ACK_LIMIT) begin
                $display("timeout: no wb_ack for access to address %0d", adr);
                abort_run();
            end
        end while (wb_ack !== 1'b1);
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic read_check(input string name, input logic [4:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        wb_read(adr, rd);
        check_word(name, exp, rd);
    endtask

    task automatic wait_flush(input int limit, input string what);
        int waited;
        waited = 0;
        while (flush !== 1'b1) begin
            if (waited >= limit) begin
                $display("timeout: no flush after %s within %0d cycles", what, limit);
                abort_run();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic run_sync(input exc_pkg::exc_flags_t f);
        exc_pkg::exc_type_e t;
        logic [31:0]        pc;
        logic               ds;
        logic [31:0]        bva;
        logic [31:0]        rd;
        t   = pick_exc(f);
        pc  = rand_word();
        ds  = rand_word() & 32'd1;
        bva = rand_word();
        pipe_flags     = f;
        pipe_pc        = pc;
        pipe_delayslot = ds;
        pipe_badvaddr  = bva;
        #2;
        check_exc("exc_type", t, dut_i.exc_bus.exc_type);
        @(negedge clk);
        pipe_flags = '0;
        wait_flush(0, t.name());
        if (t == exc_pkg::ERET) begin
            // redirect uses epc from before the commit edge
            check_word("redirect_pc", m_epc, redirect_pc);
            m_status[cp0_pkg::STATUS_EXL] = 1'b0;
        end else begin
            check_word("redirect_pc", exc_pkg::EXC_VECTOR, redirect_pc);
            m_epc = ds ? pc - 32'd4 : pc;
            m_cause = 32'd0;
            m_cause[cp0_pkg::CAUSE_BD] = ds;
            m_cause[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] = code_for(t);
            m_status[cp0_pkg::STATUS_EXL] = 1'b1;
            if (t == exc_pkg::ADEL_IF)
                m_badvaddr = pc;
            else if (t == exc_pkg::ADEL || t == exc_pkg::ADES)
                m_badvaddr = bva;
        end
        @(negedge clk);
        check_word("flush", 32'd0, {31'd0, flush});
        read_check("status", cp0_pkg::STATUS, m_status);
        read_check("epc", cp0_pkg::EPC, m_epc);
        read_check("badvaddr", cp0_pkg::BADVADDR, m_badvaddr);
        wb_read(cp0_pkg::CAUSE, rd);
        check_code("cause.exccode", cp0_pkg::exccode_e'(m_cause[6:2]),
                   cp0_pkg::exccode_e'(rd[6:2]));
        check_word("cause", m_cause, rd);
        compare_reg_ports();
    endtask

    // flush already seen; interrupt bookkeeping and cleanup
    task automatic finish_int(input logic [31:0] pc, input logic [31:0] status_off);
        logic [31:0] rd;
        check_word("redirect_pc", exc_pkg::EXC_VECTOR, redirect_pc);
        m_epc = pc;
        m_cause = 32'd0;
        m_status[cp0_pkg::STATUS_EXL] = 1'b1;
        hw_int = 5'd0;
        wb_read(cp0_pkg::CAUSE, rd);
        check_code("cause.exccode", cp0_pkg::INT, cp0_pkg::exccode_e'(rd[6:2]));
        read_check("status", cp0_pkg::STATUS, m_status);
        read_check("epc", cp0_pkg::EPC, m_epc);
        wb_write(cp0_pkg::STATUS, status_off);
        m_status = status_off;
        repeat (4) @(negedge clk);
        read_check("cause", cp0_pkg::CAUSE, m_cause);
        compare_reg_ports();
    endtask

    task automatic run_hw_int(input int line);
        logic [31:0] pc;
        pc = rand_word();
        m_status = 32'h1 | (32'h400 << line);
        wb_write(cp0_pkg::STATUS, m_status);
        pipe_pc        = pc;
        pipe_delayslot = 1'b0;
        hw_int         = 5'd1 << line;
        wait_flush(12, "hw_int pulse");
        finish_int(pc, 32'd0);
    endtask

    task automatic run_timer();
        logic [31:0] rd;
        logic [31:0] pc;
        pc = rand_word();
        wb_read(cp0_pkg::COUNT, rd);
        m_compare = rd + 32'd24;
        wb_write(cp0_pkg::COMPARE, m_compare);
        m_status = 32'h0000_8001;
        wb_write(cp0_pkg::STATUS, m_status);
        pipe_pc        = pc;
        pipe_delayslot = 1'b0;
        wait_flush(60, "compare match");
        wb_read(cp0_pkg::CAUSE, rd);
        check_word("cause.ip_timer", 32'd1, {31'd0, rd[cp0_pkg::CAUSE_IP_HI]});
        // move compare out of reach, clears the timer line
        m_compare = rand_word() | 32'h8000_0000;
        wb_write(cp0_pkg::COMPARE, m_compare);
        finish_int(pc, 32'd0);
    endtask

    initial begin
        logic [31:0] d;
        logic [4:0]  und;
        logic [7:0]  f;
        rng_state      = 32'hea6551e0;
        rst            = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = 5'd0;
        wb_dat_i       = 32'd0;
        pipe_flags     = '0;
        pipe_pc        = 32'd0;
        pipe_delayslot = 1'b0;
        pipe_badvaddr  = 32'd0;
        hw_int         = 5'd0;
        m_status       = cp0_pkg::STATUS_RESET;
        m_cause        = cp0_pkg::CAUSE_RESET;
        m_epc          = cp0_pkg::EPC_RESET;
        m_badvaddr     = cp0_pkg::BADVADDR_RESET;
        m_compare      = 32'd0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_word("flush", 32'd0, {31'd0, flush});
        check_word("wb_ack", 32'd0, {31'd0, wb_ack});

        read_check("prid", cp0_pkg::PRID, 32'h0001_8000);
        read_check("config", cp0_pkg::CONFIG, 32'h0000_8000);
        read_check("status", cp0_pkg::STATUS, 32'd0);
        read_check("cause", cp0_pkg::CAUSE, 32'd0);
        compare_reg_ports();

        for (int i = 0; i < 8; i++) begin
            d = rand_word();
            wb_write(cp0_pkg::STATUS, d);
            m_status = (m_status & ~32'h0000_fc03) | (d & 32'h0000_fc03);
            read_check("status", cp0_pkg::STATUS, m_status);
            m_epc = rand_word();
            wb_write(cp0_pkg::EPC, m_epc);
            read_check("epc", cp0_pkg::EPC, m_epc);
            m_compare = rand_word() | 32'h8000_0000;
            wb_write(cp0_pkg::COMPARE, m_compare);
            read_check("compare", cp0_pkg::COMPARE, m_compare);
            wb_write(cp0_pkg::CAUSE, rand_word());
            read_check("cause", cp0_pkg::CAUSE, m_cause);
            compare_reg_ports();
            d = rand_word();
            und = d[4] ? 5'd20 : (d[3] ? 5'd10 : {2'b00, d[2:0]});
            read_check("undefined", und, 32'd0);
        end
        wb_write(cp0_pkg::STATUS, 32'd0);
        m_status = 32'd0;

        // single exceptions, each returned from with eret
        for (int i = 0; i < 16; i++) begin
            d = rand_word() % 7;
            run_sync(exc_pkg::exc_flags_t'(8'h80 >> d));
            run_sync(exc_pkg::exc_flags_t'(8'h01));
        end

        for (int i = 0; i < 4; i++) begin
            run_hw_int(int'(rand_word() % 5));
        end
        run_timer();

        for (int i = 0; i < 12; i++) begin
            f = rand_word();
            if ($countones(f) < 2)
                f = f | 8'h21;
            run_sync(exc_pkg::exc_flags_t'(f));
            if (m_status[cp0_pkg::STATUS_EXL])
                run_sync(exc_pkg::exc_flags_t'(8'h01));
        end

        // interrupts masked by exl
        run_sync(exc_pkg::exc_flags_t'(8'h02));
        m_status = 32'h0000_fc03;
        wb_write(cp0_pkg::STATUS, m_status);
        hw_int = 5'h1f;
        repeat (12) begin
            @(negedge clk);
            check_word("flush", 32'd0, {31'd0, flush});
        end
        hw_int = 5'd0;
        repeat (4) @(negedge clk);
        wb_write(cp0_pkg::STATUS, 32'd0);
        m_status = 32'd0;
        read_check("status", cp0_pkg::STATUS, m_status);
        read_check("cause", cp0_pkg::CAUSE, m_cause);
        compare_reg_ports();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
cp0_pkg.sv
exc_pkg.sv
cp0_access_if.sv
exc_if.sv
cp0_wb_slave.sv
exc_arbiter.sv
cp0_regs.sv
exc_redirect.sv
cp0_top.sv
tb_cp0_top.sv
